/* rtl/axi_arbiter.sv */
module axi_arbiter (
   input  logic                clk,
   input  logic                rst,
   // Fetch port is read only
   input  logic                ifu_ar_valid,
   output logic                ifu_ar_ready,
   input  axi_pkg::axi_ax_t    ifu_ar,
   output logic                ifu_r_valid,
   input  logic                ifu_r_ready,
   output axi_pkg::axi_r_t     ifu_r,
   // Load/store port
   input  logic                mem_ar_valid,
   output logic                mem_ar_ready,
   input  axi_pkg::axi_ax_t    mem_ar,
   output logic                mem_r_valid,
   input  logic                mem_r_ready,
   output axi_pkg::axi_r_t     mem_r,
   input  logic                mem_aw_valid,
   output logic                mem_aw_ready,
   input  axi_pkg::axi_ax_t    mem_aw,
   input  logic                mem_w_valid,
   output logic                mem_w_ready,
   input  axi_pkg::axi_w_t     mem_w,
   output logic                mem_b_valid,
   input  logic                mem_b_ready,
   output axi_pkg::axi_resp_e  mem_b_resp,
   // Slave side
   output logic                s_ar_valid,
   input  logic                s_ar_ready,
   output axi_pkg::axi_ax_t    s_ar,
   input  logic                s_r_valid,
   output logic                s_r_ready,
   input  axi_pkg::axi_r_t     s_r,
   output logic                s_aw_valid,
   input  logic                s_aw_ready,
   output axi_pkg::axi_ax_t    s_aw,
   output logic                s_w_valid,
   input  logic                s_w_ready,
   output axi_pkg::axi_w_t     s_w,
   input  logic                s_b_valid,
   output logic                s_b_ready,
   input  axi_pkg::axi_resp_e  s_b_resp
);

   axi_pkg::arb_state_e state;
   logic                idle;
   logic                pick_ifu;                    // Fetch wins any tie

   // ****************************************
   // Read address granted only from idle
   // ****************************************
   assign idle     = (state == axi_pkg::ARB_IDLE);
   assign pick_ifu = ifu_ar_valid;

   assign s_ar_valid   = idle && (ifu_ar_valid || mem_ar_valid);
   assign s_ar         = pick_ifu ? ifu_ar : mem_ar;
   assign ifu_ar_ready = idle && pick_ifu && s_ar_ready;
   assign mem_ar_ready = idle && !pick_ifu && s_ar_ready;  // Loser sees ready low

   // Read data goes only to the owner
   assign ifu_r_valid = (state == axi_pkg::ARB_IFU) && s_r_valid;
   assign mem_r_valid = (state == axi_pkg::ARB_MEM) && s_r_valid;
   assign ifu_r       = s_r;
   assign mem_r       = s_r;

   always_comb begin
      case (state)
         axi_pkg::ARB_IFU: s_r_ready = ifu_r_ready;
         axi_pkg::ARB_MEM: s_r_ready = mem_r_ready;
         default:          s_r_ready = 1'b0;
      endcase
   end

   // Ownership taken on the AR transfer, dropped on the last beat
   always_ff @(posedge clk) begin
      if (rst) begin
         state <= axi_pkg::ARB_IDLE;
      end else if (idle) begin
         if (s_ar_valid && s_ar_ready)
            state <= pick_ifu ? axi_pkg::ARB_IFU : axi_pkg::ARB_MEM;
      end else if (s_r_valid && s_r_ready && s_r.last) begin
         state <= axi_pkg::ARB_IDLE;
      end
   end

   // ****************************************
   // Write side from the load/store port only
   // ****************************************
   assign s_aw_valid   = mem_aw_valid;
   assign s_aw         = mem_aw;
   assign mem_aw_ready = s_aw_ready;
   assign s_w_valid    = mem_w_valid;
   assign s_w          = mem_w;
   assign mem_w_ready  = s_w_ready;
   assign mem_b_valid  = s_b_valid;
   assign mem_b_resp   = s_b_resp;
   assign s_b_ready    = mem_b_ready;

   // Each slave beat reaches exactly one owner
   a_one_r_owner: assert property (@(posedge clk) disable iff (rst)
      s_r_valid |-> (ifu_r_valid ^ mem_r_valid));

   // No grant without an accepted address
   a_grant_after_accept: assert property (@(posedge clk) disable iff (rst)
      !idle |-> !s_ar_ready);

endmodule

/* rtl/axi_pkg.sv */
package axi_pkg;

   // ****************************************
   // Widths and memory geometry
   // ****************************************
   localparam int ADDR_W    = 32;
   localparam int DATA_W    = 64;
   localparam int STRB_W    = 8;                      // One strobe bit per byte
   localparam int MEM_WORDS = 256;                    // Depth in 64-bit words
   localparam int MEM_AW    = $clog2(MEM_WORDS);      // Word index width
   localparam logic [ADDR_W-1:0] MEM_BYTES = MEM_WORDS * 8;  // First byte out of range

   // AXI encodings
   typedef enum logic [1:0] {
      AXI_FIXED = 2'b00,
      AXI_INCR  = 2'b01,
      AXI_WRAP  = 2'b10
   } axi_burst_e;

   typedef enum logic [1:0] {
      AXI_OKAY   = 2'b00,
      AXI_SLVERR = 2'b10
   } axi_resp_e;

   // ****************************************
   // Channel payloads
   // ****************************************
   typedef struct packed {
      logic [ADDR_W-1:0] addr;
      logic [7:0]        len;                         // Beats minus one
      logic [2:0]        size;                        // Log2 of bytes per beat
      axi_burst_e        burst;
   } axi_ax_t;                                        // Shared by AR and AW

   typedef struct packed {
      logic [DATA_W-1:0] data;
      axi_resp_e         resp;
      logic              last;
   } axi_r_t;

   typedef struct packed {
      logic [DATA_W-1:0] data;
      logic [STRB_W-1:0] strb;
      logic              last;
   } axi_w_t;

   // Read channel ownership in the arbiter
   typedef enum logic [1:0] {ARB_IDLE, ARB_IFU, ARB_MEM} arb_state_e;

   // Port side requests and responses
   typedef enum logic {LSU_LOAD, LSU_STORE} lsu_op_e;

   typedef struct packed {
      lsu_op_e           op;
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] wdata;
      logic [STRB_W-1:0] wstrb;
   } lsu_req_t;

   typedef struct packed {
      logic [DATA_W-1:0] rdata;
      logic              err;                         // Set on SLVERR
   } lsu_rsp_t;

   typedef struct packed {
      logic [ADDR_W-1:0] addr;
      logic [7:0]        len;
   } fetch_req_t;

endpackage

/* rtl/axi_sram.sv */
module axi_sram (
   input  logic               clk,
   input  logic               rst,
   input  logic               ar_valid,
   output logic               ar_ready,
   input  axi_pkg::axi_ax_t   ar,
   output logic               r_valid,
   input  logic               r_ready,
   output axi_pkg::axi_r_t    r,
   input  logic               aw_valid,
   output logic               aw_ready,
   input  axi_pkg::axi_ax_t   aw,
   input  logic               w_valid,
   output logic               w_ready,
   input  axi_pkg::axi_w_t    w,
   output logic               b_valid,
   input  logic               b_ready,
   output axi_pkg::axi_resp_e b_resp
);

   logic [axi_pkg::DATA_W-1:0] mem [axi_pkg::MEM_WORDS];

   logic                       rd_active;            // Read burst in flight
   logic [axi_pkg::ADDR_W-1:0] rd_addr;              // Byte address of current beat
   logic [7:0]                 rd_cnt;               // Beats left after this one
   logic                       rd_err;
   logic                       aw_have;
   logic                       w_have;
   axi_pkg::axi_ax_t           aw_q;
   axi_pkg::axi_w_t            w_q;
   axi_pkg::axi_ax_t           wr_ax;
   axi_pkg::axi_w_t            wr_w;
   logic                       wr_go;
   logic                       wr_err;

   // ****************************************
   // Read side, INCR bursts
   // ****************************************
   assign ar_ready = !rd_active;
   assign r_valid  = rd_active;                      // First beat the cycle after AR
   assign rd_err   = (rd_addr >= axi_pkg::MEM_BYTES);

   always_comb begin
      r.data = rd_err ? '0 : mem[rd_addr[3 +: axi_pkg::MEM_AW]];
      r.resp = rd_err ? axi_pkg::AXI_SLVERR : axi_pkg::AXI_OKAY;
      r.last = (rd_cnt == 8'd0);
   end

   always_ff @(posedge clk) begin
      if (rst)                             rd_active <= 1'b0;
      else if (ar_valid && ar_ready)       rd_active <= 1'b1;
      else if (r_valid && r_ready && r.last) rd_active <= 1'b0;
   end

   // FIXED and WRAP also step forward
   always_ff @(posedge clk) begin
      if (ar_valid && ar_ready) begin
         rd_addr <= ar.addr;
         rd_cnt  <= ar.len;
      end else if (r_valid && r_ready) begin
         rd_addr <= rd_addr + 'd8;
         rd_cnt  <= rd_cnt - 8'd1;
      end
   end

   // ****************************************
   // Write side, AW and W in any order
   // ****************************************
   assign aw_ready = !aw_have && !b_valid;
   assign w_ready  = !w_have && !b_valid;
   assign wr_ax    = aw_have ? aw_q : aw;            // Held copy or the live beat
   assign wr_w     = w_have ? w_q : w;
   assign wr_go    = (aw_have || (aw_valid && aw_ready)) && (w_have || (w_valid && w_ready));
   assign wr_err   = (wr_ax.addr >= axi_pkg::MEM_BYTES);

   always_ff @(posedge clk) begin
      if (rst) begin
         aw_have <= 1'b0;
         w_have  <= 1'b0;
         b_valid <= 1'b0;
      end else if (wr_go) begin
         aw_have <= 1'b0;
         w_have  <= 1'b0;
         b_valid <= 1'b1;
      end else begin
         if (aw_valid && aw_ready) aw_have <= 1'b1;
         if (w_valid && w_ready)   w_have  <= 1'b1;
         if (b_valid && b_ready)   b_valid <= 1'b0;   // Response taken
      end
   end

   always_ff @(posedge clk) begin
      if (aw_valid && aw_ready) aw_q <= aw;
      if (w_valid && w_ready)   w_q  <= w;
      if (wr_go) b_resp <= wr_err ? axi_pkg::AXI_SLVERR : axi_pkg::AXI_OKAY;
   end

   // Byte lanes under strobe, out of range write dropped
   always_ff @(posedge clk) begin
      if (wr_go && !wr_err) begin
         for (int i = 0; i < axi_pkg::STRB_W; i++) begin
            if (wr_w.strb[i])
               mem[wr_ax.addr[3 +: axi_pkg::MEM_AW]][8*i +: 8] <= wr_w.data[8*i +: 8];
         end
      end
   end

endmodule

/* rtl/ifu_axi_master.sv */
module ifu_axi_master (
   input  logic                clk,
   input  logic                rst,
   input  logic                fetch_req_valid,
   output logic                fetch_req_ready,
   input  axi_pkg::fetch_req_t fetch_req,
   output logic                fetch_data_valid,
   input  logic                fetch_data_ready,
   output axi_pkg::axi_r_t     fetch_data,
   output logic                ar_valid,
   input  logic                ar_ready,
   output axi_pkg::axi_ax_t    ar,
   input  logic                r_valid,
   output logic                r_ready,
   input  axi_pkg::axi_r_t     r
);

   typedef enum logic [1:0] {IFU_IDLE, IFU_ADDR, IFU_DATA} ifu_state_e;

   ifu_state_e       state;
   axi_pkg::axi_ax_t ar_q;                            // Burst request held for AR

   assign fetch_req_ready  = (state == IFU_IDLE);
   assign ar_valid         = (state == IFU_ADDR);    // Held until the AR transfer
   assign ar               = ar_q;

   // R beats go straight out, back-pressure goes straight back
   assign fetch_data_valid = (state == IFU_DATA) && r_valid;
   assign fetch_data       = r;
   assign r_ready          = (state == IFU_DATA) && fetch_data_ready;

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= IFU_IDLE;
      end else begin
         case (state)
            IFU_IDLE: if (fetch_req_valid) state <= IFU_ADDR;
            IFU_ADDR: if (ar_ready) state <= IFU_DATA;
            IFU_DATA: if (r_valid && r_ready && r.last) state <= IFU_IDLE;  // Burst done
            default:  state <= IFU_IDLE;
         endcase
      end
   end

   // Full-width INCR burst, size 3 is eight bytes per beat
   always_ff @(posedge clk) begin
      if (fetch_req_valid && fetch_req_ready) begin
         ar_q.addr  <= fetch_req.addr;
         ar_q.len   <= fetch_req.len;
         ar_q.size  <= 3'd3;
         ar_q.burst <= axi_pkg::AXI_INCR;
      end
   end

   // Arbiter must never route R to this port while no burst is open
   a_no_r_when_idle: assert property (@(posedge clk) disable iff (rst)
      (state == IFU_IDLE) |-> !r_valid);

endmodule

/* rtl/lsu_axi_master.sv */
module lsu_axi_master (
   input  logic               clk,
   input  logic               rst,
   input  logic               lsu_req_valid,
   output logic               lsu_req_ready,
   input  axi_pkg::lsu_req_t  lsu_req,
   output logic               lsu_rsp_valid,
   output axi_pkg::lsu_rsp_t  lsu_rsp,
   output logic               ar_valid,
   input  logic               ar_ready,
   output axi_pkg::axi_ax_t   ar,
   input  logic               r_valid,
   output logic               r_ready,
   input  axi_pkg::axi_r_t    r,
   output logic               aw_valid,
   input  logic               aw_ready,
   output axi_pkg::axi_ax_t   aw,
   output logic               w_valid,
   input  logic               w_ready,
   output axi_pkg::axi_w_t    w,
   input  logic               b_valid,
   output logic               b_ready,
   input  axi_pkg::axi_resp_e b_resp
);

   typedef enum logic [2:0] {ST_IDLE, ST_AR, ST_R, ST_WR, ST_B} lsu_state_e;

   lsu_state_e        state;
   axi_pkg::lsu_req_t req_q;
   logic              aw_done;                        // AW already accepted
   logic              w_done;                         // W already accepted
   logic              aw_ok;
   logic              w_ok;
   logic              r_fire;
   logic              b_fire;

   // Single beat, same address word for AR and AW
   assign ar = '{addr: req_q.addr, len: 8'd0, size: 3'd3, burst: axi_pkg::AXI_INCR};
   assign aw = ar;
   assign w  = '{data: req_q.wdata, strb: req_q.wstrb, last: 1'b1};

   assign lsu_req_ready = (state == ST_IDLE);
   assign ar_valid      = (state == ST_AR);
   assign r_ready       = (state == ST_R);
   assign aw_valid      = (state == ST_WR) && !aw_done;
   assign w_valid       = (state == ST_WR) && !w_done;
   assign b_ready       = (state == ST_B);

   assign aw_ok  = aw_done || (aw_valid && aw_ready);  // Either order is fine
   assign w_ok   = w_done || (w_valid && w_ready);
   assign r_fire = r_valid && r_ready;
   assign b_fire = b_valid && b_ready;

   // ****************************************
   // Request FSM
   // ****************************************
   always_ff @(posedge clk) begin
      if (rst) begin
         state   <= ST_IDLE;
         aw_done <= 1'b0;
         w_done  <= 1'b0;
      end else begin
         case (state)
            ST_IDLE: begin
               if (lsu_req_valid) begin
                  case (lsu_req.op)
                     axi_pkg::LSU_STORE: state <= ST_WR;
                     default:            state <= ST_AR;
                  endcase
               end
            end
            ST_AR: if (ar_ready) state <= ST_R;
            ST_R:  if (r_fire) state <= ST_IDLE;
            ST_WR: begin
               if (aw_ok && w_ok) begin
                  state   <= ST_B;
                  aw_done <= 1'b0;
                  w_done  <= 1'b0;
               end else begin
                  aw_done <= aw_ok;
                  w_done  <= w_ok;
               end
            end
            ST_B:    if (b_fire) state <= ST_IDLE;
            default: state <= ST_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (lsu_req_valid && lsu_req_ready) req_q <= lsu_req;
   end

   // Response is a single pulse, one cycle after R or B
   always_ff @(posedge clk) begin
      if (rst) lsu_rsp_valid <= 1'b0;
      else     lsu_rsp_valid <= r_fire || b_fire;
   end

   always_ff @(posedge clk) begin
      if (r_fire) begin
         lsu_rsp.rdata <= r.data;
         lsu_rsp.err   <= (r.resp == axi_pkg::AXI_SLVERR);
      end else if (b_fire) begin
         lsu_rsp.rdata <= '0;                         // Stores return no data
         lsu_rsp.err   <= (b_resp == axi_pkg::AXI_SLVERR);
      end
   end

   // Slave and arbiter keep the single-beat read as one beat
   a_single_beat: assert property (@(posedge clk) disable iff (rst) r_fire |-> r.last);

endmodule

/* rtl/mem_subsys_top.sv */
module mem_subsys_top (
   input  logic                clk,
   input  logic                rst,
   input  logic                fetch_req_valid,
   output logic                fetch_req_ready,
   input  axi_pkg::fetch_req_t fetch_req,
   output logic                fetch_data_valid,
   input  logic                fetch_data_ready,
   output axi_pkg::axi_r_t     fetch_data,
   input  logic                lsu_req_valid,
   output logic                lsu_req_ready,
   input  axi_pkg::lsu_req_t   lsu_req,
   output logic                lsu_rsp_valid,
   output axi_pkg::lsu_rsp_t   lsu_rsp
);

   // Fetch master to arbiter
   logic               ifu_ar_valid, ifu_ar_ready, ifu_r_valid, ifu_r_ready;
   axi_pkg::axi_ax_t   ifu_ar;
   axi_pkg::axi_r_t    ifu_r;

   // Load/store master to arbiter
   logic               mem_ar_valid, mem_ar_ready, mem_r_valid, mem_r_ready;
   logic               mem_aw_valid, mem_aw_ready, mem_w_valid, mem_w_ready;
   logic               mem_b_valid, mem_b_ready;
   axi_pkg::axi_ax_t   mem_ar, mem_aw;
   axi_pkg::axi_r_t    mem_r;
   axi_pkg::axi_w_t    mem_w;
   axi_pkg::axi_resp_e mem_b_resp;

   // Arbiter to SRAM
   logic               s_ar_valid, s_ar_ready, s_r_valid, s_r_ready;
   logic               s_aw_valid, s_aw_ready, s_w_valid, s_w_ready;
   logic               s_b_valid, s_b_ready;
   axi_pkg::axi_ax_t   s_ar, s_aw;
   axi_pkg::axi_r_t    s_r;
   axi_pkg::axi_w_t    s_w;
   axi_pkg::axi_resp_e s_b_resp;

   ifu_axi_master ifu_axi_master_i (
      .clk, .rst,
      .fetch_req_valid, .fetch_req_ready, .fetch_req,
      .fetch_data_valid, .fetch_data_ready, .fetch_data,
      .ar_valid(ifu_ar_valid), .ar_ready(ifu_ar_ready), .ar(ifu_ar),
      .r_valid(ifu_r_valid), .r_ready(ifu_r_ready), .r(ifu_r)
   );

   lsu_axi_master lsu_axi_master_i (
      .clk, .rst,
      .lsu_req_valid, .lsu_req_ready, .lsu_req,
      .lsu_rsp_valid, .lsu_rsp,
      .ar_valid(mem_ar_valid), .ar_ready(mem_ar_ready), .ar(mem_ar),
      .r_valid(mem_r_valid), .r_ready(mem_r_ready), .r(mem_r),
      .aw_valid(mem_aw_valid), .aw_ready(mem_aw_ready), .aw(mem_aw),
      .w_valid(mem_w_valid), .w_ready(mem_w_ready), .w(mem_w),
      .b_valid(mem_b_valid), .b_ready(mem_b_ready), .b_resp(mem_b_resp)
   );

   axi_arbiter axi_arbiter_i (
      .clk, .rst,
      .ifu_ar_valid, .ifu_ar_ready, .ifu_ar, .ifu_r_valid, .ifu_r_ready, .ifu_r,
      .mem_ar_valid, .mem_ar_ready, .mem_ar, .mem_r_valid, .mem_r_ready, .mem_r,
      .mem_aw_valid, .mem_aw_ready, .mem_aw, .mem_w_valid, .mem_w_ready, .mem_w,
      .mem_b_valid, .mem_b_ready, .mem_b_resp,
      .s_ar_valid, .s_ar_ready, .s_ar, .s_r_valid, .s_r_ready, .s_r,
      .s_aw_valid, .s_aw_ready, .s_aw, .s_w_valid, .s_w_ready, .s_w,
      .s_b_valid, .s_b_ready, .s_b_resp
   );

   axi_sram axi_sram_i (
      .clk, .rst,
      .ar_valid(s_ar_valid), .ar_ready(s_ar_ready), .ar(s_ar),
      .r_valid(s_r_valid), .r_ready(s_r_ready), .r(s_r),
      .aw_valid(s_aw_valid), .aw_ready(s_aw_ready), .aw(s_aw),
      .w_valid(s_w_valid), .w_ready(s_w_ready), .w(s_w),
      .b_valid(s_b_valid), .b_ready(s_b_ready), .b_resp(s_b_resp)
   );

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the testbench with Verilator, pass only if the log holds the pass line
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_mem_subsys -f tb.f \
   -o tb_mem_subsys > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_mem_subsys > sim.log 2>&1 || echo "simulator returned an error status"
cat sim.log
grep -qx "Everything OK" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

/* tb.f */
rtl/axi_pkg.sv
rtl/ifu_axi_master.sv
rtl/lsu_axi_master.sv
rtl/axi_arbiter.sv
rtl/axi_sram.sv
rtl/mem_subsys_top.sv
testbench/tb_mem_subsys.sv

/* testbench/mem_stimulus.txt */
# Columns in hex. S addr wdata wstrb err | L addr rdata err
# F addr len word0 .. wordN | D faddr flen word0 .. wordN laddr rdata err
S 00000000 1111111111111111 ff 0
S 00000008 2222222222222222 ff 0
S 00000010 3333333333333333 ff 0
S 00000018 4444444444444444 ff 0
S 00000020 0123456789abcdef ff 0
S 00000028 5555555555555555 ff 0
L 00000000 1111111111111111 0
L 00000018 4444444444444444 0
S 00000008 aaaaaaaaaaaaaaaa 0f 0
L 00000008 22222222aaaaaaaa 0
S 00000020 ffeeddccbbaa9988 a5 0
L 00000020 ff23dd6789aacd88 0
F 00000000 3 1111111111111111 22222222aaaaaaaa 3333333333333333 4444444444444444
F 00000010 2 3333333333333333 4444444444444444 ff23dd6789aacd88
F 00000008 4 22222222aaaaaaaa 3333333333333333 4444444444444444 ff23dd6789aacd88 5555555555555555
S 00000800 deadbeefdeadbeef ff 1
L 00000800 0000000000000000 1
L 00000ff8 0000000000000000 1
L 00000000 1111111111111111 0
D 00000008 1 22222222aaaaaaaa 3333333333333333 00000018 4444444444444444 0
D 00000000 0 1111111111111111 00000028 5555555555555555 0
S 00000010 0000000000000077 01 0
L 00000010 3333333333333377 0
D 00000010 1 3333333333333377 4444444444444444 00000810 0000000000000000 1

/* testbench/tb_mem_subsys.sv */
module tb_mem_subsys;
   timeunit 1ns;
   timeprecision 1ps;

   logic                clk = 1'b0;
   logic                rst;
   logic                fetch_req_valid;
   logic                fetch_req_ready;
   axi_pkg::fetch_req_t fetch_req;
   logic                fetch_data_valid;
   logic                fetch_data_ready;
   axi_pkg::axi_r_t     fetch_data;
   logic                lsu_req_valid;
   logic                lsu_req_ready;
   axi_pkg::lsu_req_t   lsu_req;
   logic                lsu_rsp_valid;
   axi_pkg::lsu_rsp_t   lsu_rsp;

   // Parsed stimulus, operands of command k start at ops[starts[k]]
   logic [7:0]          cmds[$];
   int                  starts[$];
   logic [63:0]         ops[$];
   bit                  loaded = 1'b0;
   bit                  bad_file = 1'b0;

   int                  mismatch_errors = 0;
   int                  other_errors = 0;
   int                  cycle = 0;                    // Rising edges since start
   int                  fetch_done_cycle;
   int                  lsu_done_cycle;
   logic [31:0]         lcg_state = 32'ha453da15;

   mem_subsys_top mem_subsys_top_i (
      .clk, .rst,
      .fetch_req_valid, .fetch_req_ready, .fetch_req,
      .fetch_data_valid, .fetch_data_ready, .fetch_data,
      .lsu_req_valid, .lsu_req_ready, .lsu_req,
      .lsu_rsp_valid, .lsu_rsp
   );

   always #20 clk = ~clk;                             // 40 ns period

   always @(posedge clk) cycle = cycle + 1;

   // ****************************************
   // Helpers
   // ****************************************
   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // Ready low on about one cycle in four
   task automatic drive_fetch_ready();
      lcg_state        = lcg_next(lcg_state);
      fetch_data_ready = (lcg_state[31:30] != 2'b00);
   endtask

   task automatic check_fetch(input axi_pkg::axi_r_t exp, input axi_pkg::axi_r_t act,
                              input int beat);
      if (act.data !== exp.data || act.resp !== exp.resp) begin
         mismatch_errors++;
         $display("mismatch at %0t: fetch beat %0d expected data %h resp %h, got data %h resp %h",
                  $time, beat, exp.data, exp.resp, act.data, act.resp);
      end
      if (act.last !== exp.last) begin
         other_errors++;
         if (exp.last)
            $display("fetch burst ended at %0t without last on its final beat", $time);
         else
            $display("fetch beat %0d carried last before the burst was complete", beat);
      end
   endtask

   task automatic check_lsu(input axi_pkg::lsu_rsp_t exp, input axi_pkg::lsu_rsp_t act,
                            input bit with_data);
      if (act.err !== exp.err || (with_data && act.rdata !== exp.rdata)) begin
         mismatch_errors++;
         $display("mismatch at %0t: lsu response expected rdata %h err %b, got rdata %h err %b",
                  $time, exp.rdata, exp.err, act.rdata, act.err);
      end
   endtask

   // Nothing may come out while both ports are idle
   task automatic check_quiet(input int cycles);
      repeat (cycles) begin
         @(negedge clk);
         if (fetch_data_valid) begin
            other_errors++;
            $display("stray fetch beat at %0t with no fetch open", $time);
         end
         if (lsu_rsp_valid) begin
            other_errors++;
            $display("stray load/store response at %0t with no request open", $time);
         end
         if (!fetch_req_ready || !lsu_req_ready) begin
            other_errors++;
            $display("request ready low at %0t while the subsystem is idle", $time);
         end
      end
   endtask

   // ****************************************
   // Stimulus file
   // ****************************************
   task automatic read_values(input int fd, input int count);
      int          code;
      logic [63:0] v;
      for (int i = 0; i < count; i++) begin
         code = $fscanf(fd, " %h", v);
         if (code != 1) begin
            if (!bad_file) $display("stimulus file ends inside a command");
            bad_file = 1'b1;
         end else begin
            ops.push_back(v);
         end
      end
   endtask

   task automatic load_stimulus(output bit ok);
      int                 fd;
      int                 code;
      int                 words;
      bit                 done;
      logic [7:0]         c;
      logic [8*256-1:0]   line;
      done = 1'b0;
      fd   = $fopen("testbench/mem_stimulus.txt", "r");
      if (fd == 0) begin
         $display("cannot open stimulus file testbench/mem_stimulus.txt");
         bad_file = 1'b1;
      end else begin
         while (!done && !bad_file) begin
            code = $fscanf(fd, " %c", c);
            if (code != 1) begin
               done = 1'b1;                           // End of file
            end else if (c == "#") begin
               code = $fgets(line, fd);               // Skip comment line
            end else if (c == "S" || c == "L" || c == "F" || c == "D") begin
               cmds.push_back(c);
               starts.push_back(ops.size());
               read_values(fd, (c == "S") ? 4 : (c == "L") ? 3 : 2);
               if (!bad_file && (c == "F" || c == "D")) begin
                  words = ops[$][31:0] + 1;           // len + 1 expected beats
                  read_values(fd, words);
                  if (c == "D") read_values(fd, 3);   // Load part
               end
            end else begin
               $display("unknown command %c in stimulus file", c);
               bad_file = 1'b1;
            end
         end
         $fclose(fd);
      end
      if (!bad_file && cmds.size() == 0) begin
         $display("stimulus file holds no commands");
         bad_file = 1'b1;
      end
      ok = !bad_file;
   endtask

   // ****************************************
   // Port drivers, all action on the falling edge
   // ****************************************
   task automatic fetch_run(input logic [31:0] addr, input int len, input int wbase);
      axi_pkg::axi_r_t exp;
      int              beat;
      bit              accepted;
      beat               = 0;
      accepted           = 1'b0;
      fetch_req.addr     = addr;
      fetch_req.len      = len[7:0];
      fetch_req_valid    = 1'b1;
      while (beat <= len) begin
         drive_fetch_ready();
         if (fetch_data_valid && fetch_data_ready) begin   // Beat moves on next rising edge
            exp.data = ops[wbase+beat];
            exp.resp = axi_pkg::AXI_OKAY;
            exp.last = (beat == len);
            check_fetch(exp, fetch_data, beat);
            if (beat == len) fetch_done_cycle = cycle;
            beat++;
         end
         if (fetch_req_valid && fetch_req_ready) accepted = 1'b1;
         @(negedge clk);
         if (accepted) fetch_req_valid = 1'b0;
      end
   endtask

   task automatic lsu_run(input axi_pkg::lsu_op_e op, input logic [31:0] addr,
                          input logic [63:0] wdata, input logic [7:0] wstrb,
                          input logic [63:0] exp_data, input logic exp_err,
                          input bit with_data);
      axi_pkg::lsu_rsp_t exp;
      bit                accepted;
      bit                got;
      accepted       = 1'b0;
      got            = 1'b0;
      exp.rdata      = exp_data;
      exp.err        = exp_err;
      lsu_req.op     = op;
      lsu_req.addr   = addr;
      lsu_req.wdata  = wdata;
      lsu_req.wstrb  = wstrb;
      lsu_req_valid  = 1'b1;
      while (!got) begin
         if (lsu_rsp_valid) begin                     // One-cycle pulse, no ready
            check_lsu(exp, lsu_rsp, with_data);
            lsu_done_cycle = cycle;
            got = 1'b1;
         end else begin
            if (lsu_req_valid && lsu_req_ready) accepted = 1'b1;
            @(negedge clk);
            if (accepted) lsu_req_valid = 1'b0;
         end
      end
   endtask

   task automatic run_commands();
      int s;
      int n;
      for (int k = 0; k < cmds.size(); k++) begin
         s = starts[k];
         case (cmds[k])
            "S": lsu_run(axi_pkg::LSU_STORE, ops[s][31:0], ops[s+1], ops[s+2][7:0],
                         '0, ops[s+3][0], 1'b0);      // Stores check err only
            "L": lsu_run(axi_pkg::LSU_LOAD, ops[s][31:0], '0, '0,
                         ops[s+1], ops[s+2][0], 1'b1);
            "F": fetch_run(ops[s][31:0], ops[s+1][31:0], s + 2);
            "D": begin
               n = ops[s+1][31:0] + 1;
               fork                                   // Both requests raised together
                  fetch_run(ops[s][31:0], ops[s+1][31:0], s + 2);
                  lsu_run(axi_pkg::LSU_LOAD, ops[s+2+n][31:0], '0, '0,
                          ops[s+3+n], ops[s+4+n][0], 1'b1);
               join
               if (!(fetch_done_cycle < lsu_done_cycle)) begin
                  other_errors++;
                  $display("load response arrived before the fetch burst finished at %0t",
                           $time);
               end
            end
            default: begin
               other_errors++;
               $display("command %0d has an unknown kind", k);
            end
         endcase
         check_quiet(2);
      end
   endtask

   task automatic report_and_finish();
      $display("errors: %0d mismatches, %0d other failures", mismatch_errors, other_errors);
      if (mismatch_errors == 0 && other_errors == 0)
         $display("Everything OK");
      else
         $display("Something failed");
      $finish;
   endtask

   // ****************************************
   // Main sequence and watchdog
   // ****************************************
   initial begin
      bit ok;
      rst              = 1'b1;
      fetch_req_valid  = 1'b0;
      fetch_req        = '0;
      fetch_data_ready = 1'b1;
      lsu_req_valid    = 1'b0;
      lsu_req          = '0;
      load_stimulus(ok);
      loaded = ok;
      repeat (3) @(negedge clk);                      // Three rising edges in reset
      rst = 1'b0;
      check_quiet(4);                                 // Outputs after reset
      if (ok)
         run_commands();
      else
         other_errors++;
      report_and_finish();
   end

   initial begin
      int timeout_ns;
      wait (loaded);
      timeout_ns = cmds.size() * 200 * 40;            // 200 cycles per command
      #(timeout_ns);
      other_errors++;
      $display("timeout: run still busy after %0d ns", timeout_ns);
      report_and_finish();
   end

endmodule
